// File: design/flit_packer.sv
`timescale 1ns/1ps

//////////////////////////////
// Request flit packer
// Builds AW, W and AR flits and keeps each
// write burst right behind its AW on the write lane
//////////////////////////////

module flit_packer import noc_pkg::*; #(
  parameter int unsigned IdAddrOffset = 16
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  node_id_t  node_id_i,
  input  axi_req_t  axi_req_i,
  input  logic      wr_gnt_i,
  input  logic      rd_gnt_i,
  output logic      aw_ready_o,
  output logic      w_ready_o,
  output logic      ar_ready_o,
  output req_flit_t wr_flit_o,
  output req_flit_t rd_flit_o,
  output logic      wr_valid_o,
  output logic      rd_valid_o
);

  // Set while the W beats of a burst are due
  logic      w_phase_q;
  node_id_t  wr_dst_q;
  node_id_t  aw_dst;
  node_id_t  ar_dst;
  logic      aw_fire;
  logic      w_last_fire;
  req_flit_t aw_flit;
  req_flit_t w_flit;

  // Offset-based ID routing
  assign aw_dst = axi_req_i.aw.addr[IdAddrOffset +: NodeIdWidth];
  assign ar_dst = axi_req_i.ar.addr[IdAddrOffset +: NodeIdWidth];

  //////////////////////////////
  // Flit forming
  //////////////////////////////

  always_comb begin
    aw_flit            = '0;
    aw_flit.hdr.dst_id = aw_dst;
    aw_flit.hdr.src_id = node_id_i;
    aw_flit.hdr.last   = 1'b0;
    aw_flit.hdr.axi_ch = Aw;
    aw_flit.payload[$bits(aw_chan_t)-1:0] = axi_req_i.aw;
  end

  always_comb begin
    w_flit            = '0;
    w_flit.hdr.dst_id = wr_dst_q;
    w_flit.hdr.src_id = node_id_i;
    w_flit.hdr.last   = axi_req_i.w.last;
    w_flit.hdr.axi_ch = W;
    w_flit.payload[$bits(w_chan_t)-1:0] = axi_req_i.w;
  end

  // A read is always a single flit
  always_comb begin
    rd_flit_o            = '0;
    rd_flit_o.hdr.dst_id = ar_dst;
    rd_flit_o.hdr.src_id = node_id_i;
    rd_flit_o.hdr.last   = 1'b1;
    rd_flit_o.hdr.axi_ch = Ar;
    rd_flit_o.payload[$bits(aw_chan_t)-1:0] = axi_req_i.ar;
  end

  assign wr_flit_o  = w_phase_q ? w_flit : aw_flit;
  assign wr_valid_o = w_phase_q ? axi_req_i.w_valid : axi_req_i.aw_valid;
  assign rd_valid_o = axi_req_i.ar_valid;

  // Core readies follow the arbiter grants
  assign aw_ready_o = wr_gnt_i && !w_phase_q;
  assign w_ready_o  = wr_gnt_i && w_phase_q;
  assign ar_ready_o = rd_gnt_i;

  assign aw_fire     = axi_req_i.aw_valid && aw_ready_o;
  assign w_last_fire = axi_req_i.w_valid && w_ready_o && axi_req_i.w.last;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      w_phase_q <= 1'b0;
    end else if (aw_fire) begin
      w_phase_q <= 1'b1;
    end else if (w_last_fire) begin
      w_phase_q <= 1'b0;
    end
  end

  // Destination of the open burst
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      wr_dst_q <= aw_dst;
    end
  end

  // W beats come only after their AW has been accepted
  a_no_w_in_aw_phase: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !w_phase_q |-> !axi_req_i.w_valid)
    else $error("W flit offered in the AW phase");

endmodule

// File: design/noc_chimney.sv
`timescale 1ns/1ps

//////////////////////////////
// NoC chimney, manager side
// Core AXI channels to request flits and
// response flits back to B and R
//////////////////////////////

module noc_chimney import noc_pkg::*; #(
  parameter int unsigned IdAddrOffset = 16
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  node_id_t  node_id_i,
  input  axi_req_t  axi_req_i,
  output axi_rsp_t  axi_rsp_o,
  output req_flit_t req_flit_o,
  output logic      req_valid_o,
  input  logic      req_ready_i,
  input  rsp_flit_t rsp_flit_i,
  input  logic      rsp_valid_i,
  output logic      rsp_ready_o
);

  // Request path
  req_flit_t wr_flit;
  req_flit_t rd_flit;
  logic      wr_valid;
  logic      rd_valid;
  logic      wr_gnt;
  logic      rd_gnt;
  logic      aw_ready;
  logic      w_ready;
  logic      ar_ready;

  // Response path
  rsp_flit_t buf_flit;
  logic      buf_valid;
  logic      buf_ready;
  b_chan_t   b;
  r_chan_t   r;
  logic      b_valid;
  logic      r_valid;

  //////////////////////////////
  // Requests
  //////////////////////////////

  flit_packer #(
    .IdAddrOffset ( IdAddrOffset )
  ) i_flit_packer (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .node_id_i  ( node_id_i ),
    .axi_req_i  ( axi_req_i ),
    .wr_gnt_i   ( wr_gnt    ),
    .rd_gnt_i   ( rd_gnt    ),
    .aw_ready_o ( aw_ready  ),
    .w_ready_o  ( w_ready   ),
    .ar_ready_o ( ar_ready  ),
    .wr_flit_o  ( wr_flit   ),
    .rd_flit_o  ( rd_flit   ),
    .wr_valid_o ( wr_valid  ),
    .rd_valid_o ( rd_valid  )
  );

  wormhole_arbiter i_wormhole_arbiter (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .wr_flit_i   ( wr_flit     ),
    .rd_flit_i   ( rd_flit     ),
    .wr_valid_i  ( wr_valid    ),
    .rd_valid_i  ( rd_valid    ),
    .req_ready_i ( req_ready_i ),
    .wr_gnt_o    ( wr_gnt      ),
    .rd_gnt_o    ( rd_gnt      ),
    .req_valid_o ( req_valid_o ),
    .req_flit_o  ( req_flit_o  )
  );

  //////////////////////////////
  // Responses
  //////////////////////////////

  rsp_spill_register i_rsp_spill_register (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .flit_i  ( rsp_flit_i  ),
    .valid_i ( rsp_valid_i ),
    .ready_o ( rsp_ready_o ),
    .flit_o  ( buf_flit    ),
    .valid_o ( buf_valid   ),
    .ready_i ( buf_ready   )
  );

  rsp_unpacker i_rsp_unpacker (
    .flit_i    ( buf_flit          ),
    .valid_i   ( buf_valid         ),
    .b_ready_i ( axi_req_i.b_ready ),
    .r_ready_i ( axi_req_i.r_ready ),
    .ready_o   ( buf_ready         ),
    .b_o       ( b                 ),
    .r_o       ( r                 ),
    .b_valid_o ( b_valid           ),
    .r_valid_o ( r_valid           )
  );

  assign axi_rsp_o = '{
    aw_ready : aw_ready,
    w_ready  : w_ready,
    ar_ready : ar_ready,
    b        : b,
    b_valid  : b_valid,
    r        : r,
    r_valid  : r_valid
  };

endmodule

// File: design/noc_pkg.sv
//////////////////////////////
// NoC chimney package
// Widths, channel tags, AXI channel structs and flit types
//////////////////////////////

package noc_pkg;

  localparam int unsigned NodeIdWidth = 6;
  localparam int unsigned AxiIdWidth  = 4;
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;

  typedef logic [NodeIdWidth-1:0] node_id_t;

  // Channel tag carried in every flit header
  typedef enum logic [2:0] {
    Aw = 3'd0,
    W  = 3'd1,
    Ar = 3'd2,
    B  = 3'd3,
    R  = 3'd4
  } axi_ch_e;

  //////////////////////////////
  // AXI channels
  //////////////////////////////

  // Shared by AW and AR
  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
    logic [7:0]            len;
  } aw_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0]   data;
    logic [DataWidth/8-1:0] strb;
    logic                   last;
  } w_chan_t;

  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    logic [1:0]            resp;
  } b_chan_t;

  typedef struct packed {
    logic [AxiIdWidth-1:0] id;
    logic [DataWidth-1:0]  data;
    logic [1:0]            resp;
    logic                  last;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    aw_chan_t ar;
    logic     ar_valid;
    logic     b_ready;
    logic     r_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    ar_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } axi_rsp_t;

  //////////////////////////////
  // Flits
  //////////////////////////////

  typedef struct packed {
    node_id_t dst_id;
    node_id_t src_id;
    logic     last;
    axi_ch_e  axi_ch;
  } flit_hdr_t;

  localparam int unsigned ReqPayloadWidth = $bits(aw_chan_t);
  localparam int unsigned RspPayloadWidth = $bits(r_chan_t);

  // Channel struct sits in the low payload bits, the rest is zero
  typedef struct packed {
    flit_hdr_t                  hdr;
    logic [ReqPayloadWidth-1:0] payload;
  } req_flit_t;

  typedef struct packed {
    flit_hdr_t                  hdr;
    logic [RspPayloadWidth-1:0] payload;
  } rsp_flit_t;

endpackage

// File: design/rsp_spill_register.sv
`timescale 1ns/1ps

//////////////////////////////
// Response spill register
// Two-entry buffer, full throughput,
// no path from ready_i to ready_o
//////////////////////////////

module rsp_spill_register import noc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  rsp_flit_t flit_i,
  input  logic      valid_i,
  input  logic      ready_i,
  output logic      ready_o,
  output logic      valid_o,
  output rsp_flit_t flit_o
);

  rsp_flit_t a_flit_q;
  rsp_flit_t b_flit_q;
  logic      a_full_q;
  logic      b_full_q;
  logic      a_fill;
  logic      a_drain;
  logic      b_fill;
  logic      b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  // A moves to B only when the output is stalled
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_flit_q <= flit_i;
    end
    if (b_fill) begin
      b_flit_q <= a_flit_q;
    end
  end

  // B always holds the older flit
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign flit_o  = b_full_q ? b_flit_q : a_flit_q;

endmodule

// File: design/rsp_unpacker.sv
`timescale 1ns/1ps

//////////////////////////////
// Response unpacker
// Steers B and R flits to the core by tag
//////////////////////////////

module rsp_unpacker import noc_pkg::*; (
  input  rsp_flit_t flit_i,
  input  logic      valid_i,
  input  logic      b_ready_i,
  input  logic      r_ready_i,
  output logic      ready_o,
  output b_chan_t   b_o,
  output r_chan_t   r_o,
  output logic      b_valid_o,
  output logic      r_valid_o
);

  logic is_b;
  logic is_r;

  assign is_b = flit_i.hdr.axi_ch == B;
  assign is_r = flit_i.hdr.axi_ch == R;

  // Payload fields sit in the low bits
  assign b_o = flit_i.payload[$bits(b_chan_t)-1:0];
  assign r_o = flit_i.payload[$bits(r_chan_t)-1:0];

  assign b_valid_o = valid_i && is_b;
  assign r_valid_o = valid_i && is_r;

  always_comb begin
    ready_o = 1'b0;
    if (is_b) begin
      ready_o = b_ready_i;
    end else if (is_r) begin
      ready_o = r_ready_i;
    end
  end

  // Only responses arrive on this link
  always_comb begin
    if (valid_i) begin
      assert final (is_b || is_r)
        else $error("response flit with tag %0d", flit_i.hdr.axi_ch);
    end
  end

endmodule

// File: design/wormhole_arbiter.sv
`timescale 1ns/1ps

//////////////////////////////
// Wormhole arbiter
// Round-robin over write and read lanes,
// held on one lane until its last flit passes
//////////////////////////////

module wormhole_arbiter import noc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  req_flit_t wr_flit_i,
  input  req_flit_t rd_flit_i,
  input  logic      wr_valid_i,
  input  logic      rd_valid_i,
  input  logic      req_ready_i,
  output logic      wr_gnt_o,
  output logic      rd_gnt_o,
  output logic      req_valid_o,
  output req_flit_t req_flit_o
);

  // Lane granted most recently, 1 for read
  logic last_rd_q;
  logic lock_q;
  logic lock_rd_q;
  logic sel_rd;
  logic fire;

  always_comb begin
    if (lock_q) begin
      sel_rd = lock_rd_q;
    end else if (wr_valid_i && rd_valid_i) begin
      sel_rd = !last_rd_q;
    end else begin
      sel_rd = rd_valid_i;
    end
  end

  assign req_valid_o = sel_rd ? rd_valid_i : wr_valid_i;
  assign req_flit_o  = sel_rd ? rd_flit_i : wr_flit_i;
  assign fire        = req_valid_o && req_ready_i;
  assign wr_gnt_o    = fire && !sel_rd;
  assign rd_gnt_o    = fire && sel_rd;

  // A stalled flit or an open worm keeps the lane
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_rd_q <= 1'b1;
      lock_q    <= 1'b0;
      lock_rd_q <= 1'b0;
    end else if (req_valid_o) begin
      lock_q    <= !(req_ready_i && req_flit_o.hdr.last);
      lock_rd_q <= sel_rd;
      if (req_ready_i) begin
        last_rd_q <= sel_rd;
      end
    end
  end

  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_flit_o))
    else $error("request flit changed while stalled");

endmodule

// File: flist.f
design/noc_pkg.sv
design/flit_packer.sv
design/wormhole_arbiter.sv
design/rsp_spill_register.sv
design/rsp_unpacker.sv
design/noc_chimney.sv
verif/tb_noc_chimney.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_noc_chimney -f flist.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

// File: verif/tb_noc_chimney.sv
`timescale 1ns/1ps

//////////////////////////////
// NoC chimney testbench
// Request flit and response checks against a reference model
//////////////////////////////

module tb_noc_chimney import noc_pkg::*; ();

  localparam int unsigned IdAddrOffset = 16;
  localparam node_id_t    NodeId       = 6'h0b;
  localparam int          Timeout      = 1000;

  logic      clk_i;
  logic      rst_n_i;
  aw_chan_t  aw;
  w_chan_t   w;
  aw_chan_t  ar;
  logic      aw_valid;
  logic      w_valid;
  logic      ar_valid;
  logic      b_ready;
  logic      r_ready;
  axi_req_t  axi_req;
  axi_rsp_t  axi_rsp;
  req_flit_t req_flit;
  logic      req_valid;
  logic      req_ready;
  rsp_flit_t rsp_flit;
  logic      rsp_valid;
  logic      rsp_ready;

  logic [31:0] rng_state = 32'd70707;
  int          errors;
  int          checks;
  int          cycle;
  int          flits_seen;
  int          flits_expected;
  int          err_base;
  int          seen_base;
  int          exp_base;
  logic        stall_req;
  logic        stall_rsp;
  req_flit_t   exp_wr_q[$];
  req_flit_t   exp_rd_q[$];
  b_chan_t     exp_b_q[$];
  r_chan_t     exp_r_q[$];
  int          exp_b_cyc[$];
  int          exp_r_cyc[$];
  int          req_cyc_q[$];

  assign axi_req = '{aw: aw, aw_valid: aw_valid, w: w, w_valid: w_valid, ar: ar,
                     ar_valid: ar_valid, b_ready: b_ready, r_ready: r_ready};

  noc_chimney #(
    .IdAddrOffset ( IdAddrOffset )
  ) noc_chimney_i (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .node_id_i   ( NodeId    ),
    .axi_req_i   ( axi_req   ),
    .axi_rsp_o   ( axi_rsp   ),
    .req_flit_o  ( req_flit  ),
    .req_valid_o ( req_valid ),
    .req_ready_i ( req_ready ),
    .rsp_flit_i  ( rsp_flit  ),
    .rsp_valid_i ( rsp_valid ),
    .rsp_ready_o ( rsp_ready )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // W flits route by the address of their burst's AW
  function automatic req_flit_t expected_req_flit(input axi_ch_e ch, input aw_chan_t ax,
                                                  input w_chan_t wb);
    req_flit_t f;
    f            = '0;
    f.hdr.dst_id = ax.addr[IdAddrOffset +: NodeIdWidth];
    f.hdr.src_id = NodeId;
    f.hdr.axi_ch = ch;
    if (ch == W) begin
      f.hdr.last = wb.last;
      f.payload  = {{(ReqPayloadWidth-$bits(w_chan_t)){1'b0}}, wb};
    end else begin
      f.hdr.last = (ch == Ar);
      f.payload  = ax;
    end
    return f;
  endfunction

  function automatic aw_chan_t random_ax(input int unsigned max_len);
    aw_chan_t a;
    a.id   = 4'(next_random());
    a.addr = next_random();
    a.len  = 8'(next_random() % max_len);
    return a;
  endfunction

  task automatic check_req_flit(input req_flit_t got, input req_flit_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch req_flit_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_b(input b_chan_t got, input b_chan_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch axi_rsp_o.b: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_r(input r_chan_t got, input r_chan_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch axi_rsp_o.r: got %h expected %h", got, exp);
    end
  endtask

  function automatic logic ready_of(input int which);
    case (which)
      0:       return axi_rsp.aw_ready;
      1:       return axi_rsp.w_ready;
      2:       return axi_rsp.ar_ready;
      default: return rsp_ready;
    endcase
  endfunction

  // Valid is already up, so ready alone marks the transfer
  task automatic wait_accept(input int which, input string what);
    int cnt;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!ready_of(which) && cnt < Timeout);
    if (!ready_of(which)) begin
      errors++;
      $display("timeout waiting for %s", what);
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while ((exp_wr_q.size() + exp_rd_q.size() + exp_b_q.size() + exp_r_q.size()) != 0
           && cnt < 2 * Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (cnt >= 2 * Timeout) begin
      errors++;
      $display("timeout with %0d write, %0d read, %0d B and %0d R items outstanding",
               exp_wr_q.size(), exp_rd_q.size(), exp_b_q.size(), exp_r_q.size());
    end
  endtask

  task automatic start_test();
    err_base  = errors;
    seen_base = flits_seen;
    exp_base  = flits_expected;
    req_cyc_q.delete();
  endtask

  task automatic finish_test(input string name);
    wait_drain();
    checks++;
    if (flits_seen - seen_base != flits_expected - exp_base) begin
      errors++;
      $display("%s saw %0d request flits where %0d were sent", name,
               flits_seen - seen_base, flits_expected - exp_base);
    end
    if (errors == err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_base);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic send_write(input aw_chan_t a, input bit gaps);
    w_chan_t wb;
    exp_wr_q.push_back(expected_req_flit(Aw, a, '0));
    flits_expected++;
    @(posedge clk_i);
    aw       <= a;
    aw_valid <= 1'b1;
    wait_accept(0, "aw_ready");
    @(posedge clk_i);
    aw_valid <= 1'b0;
    for (int i = 0; i <= int'(a.len); i++) begin
      wb.data = next_random();
      wb.strb = 4'(next_random());
      wb.last = (i == int'(a.len));
      exp_wr_q.push_back(expected_req_flit(W, a, wb));
      flits_expected++;
      if (gaps) begin
        w_valid <= 1'b0;
        repeat (next_random() % 3) @(posedge clk_i);
      end
      w       <= wb;
      w_valid <= 1'b1;
      wait_accept(1, "w_ready");
      @(posedge clk_i);
    end
    w_valid <= 1'b0;
  endtask

  task automatic send_read(input aw_chan_t a, input bit gaps);
    exp_rd_q.push_back(expected_req_flit(Ar, a, '0));
    flits_expected++;
    @(posedge clk_i);
    if (gaps) begin
      repeat (next_random() % 3) @(posedge clk_i);
    end
    ar       <= a;
    ar_valid <= 1'b1;
    wait_accept(2, "ar_ready");
    @(posedge clk_i);
    ar_valid <= 1'b0;
  endtask

  // Back-to-back response flits recorded at acceptance
  task automatic send_responses(input int count);
    rsp_flit_t f;
    b_chan_t   b;
    r_chan_t   r;
    @(posedge clk_i);
    for (int i = 0; i < count; i++) begin
      f            = '0;
      f.hdr.dst_id = NodeId;
      f.hdr.src_id = 6'(next_random());
      b.id         = 4'(next_random());
      b.resp       = 2'(next_random());
      r.id         = 4'(next_random());
      r.data       = next_random();
      r.resp       = 2'(next_random());
      r.last       = next_random() > 32'h8000_0000;
      if (next_random() % 2 == 0) begin
        f.hdr.axi_ch = B;
        f.payload    = {{(RspPayloadWidth-$bits(b_chan_t)){1'b0}}, b};
      end else begin
        f.hdr.axi_ch = R;
        f.hdr.last   = r.last;
        f.payload    = r;
      end
      rsp_flit  <= f;
      rsp_valid <= 1'b1;
      wait_accept(3, "rsp_ready_o");
      if (f.hdr.axi_ch == B) begin
        exp_b_q.push_back(b);
        exp_b_cyc.push_back(cycle);
      end else begin
        exp_r_q.push_back(r);
        exp_r_cyc.push_back(cycle);
      end
      @(posedge clk_i);
    end
    rsp_valid <= 1'b0;
  endtask

  initial begin : ready_driver
    logic [31:0] rnd;
    cycle     = 0;
    req_ready = 1'b1;
    b_ready   = 1'b1;
    r_ready   = 1'b1;
    forever begin
      @(posedge clk_i);
      rnd = next_random();
      cycle     <= cycle + 1;
      req_ready <= !stall_req || rnd[0];
      b_ready   <= !stall_rsp || rnd[1];
      r_ready   <= !stall_rsp || rnd[2];
    end
  end

  //////////////////////////////
  // Monitor
  //////////////////////////////

  initial begin : monitor
    bit in_burst;
    in_burst = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && req_valid && req_ready) begin
        flits_seen++;
        req_cyc_q.push_back(cycle);
        if (req_flit.hdr.axi_ch == Ar) begin
          if (in_burst) begin
            errors++;
            $display("AR flit sent inside an open write burst");
          end
          if (exp_rd_q.size() == 0) begin
            errors++;
            $display("AR flit sent with no read outstanding");
          end else begin
            check_req_flit(req_flit, exp_rd_q.pop_front());
          end
        end else begin
          if (exp_wr_q.size() == 0) begin
            errors++;
            $display("write lane flit sent with nothing outstanding");
          end else begin
            check_req_flit(req_flit, exp_wr_q.pop_front());
          end
          if (req_flit.hdr.axi_ch == Aw) begin
            in_burst = 1'b1;
          end else if (req_flit.hdr.last) begin
            in_burst = 1'b0;
          end
        end
      end
      if (rst_n_i && axi_rsp.b_valid) begin
        if (exp_b_q.size() == 0) begin
          errors++;
          $display("B response with nothing outstanding");
        end else begin
          if (exp_b_cyc[0] >= cycle) begin
            errors++;
            $display("B valid in the cycle its flit was accepted");
          end
          if (b_ready) begin
            check_b(axi_rsp.b, exp_b_q.pop_front());
            exp_b_cyc.delete(0);
          end
        end
      end
      if (rst_n_i && axi_rsp.r_valid) begin
        if (exp_r_q.size() == 0) begin
          errors++;
          $display("R response with nothing outstanding");
        end else begin
          if (exp_r_cyc[0] >= cycle) begin
            errors++;
            $display("R valid in the cycle its flit was accepted");
          end
          if (r_ready) begin
            check_r(axi_rsp.r, exp_r_q.pop_front());
            exp_r_cyc.delete(0);
          end
        end
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    aw        = '0;
    w         = '0;
    ar        = '0;
    aw_valid  = 1'b0;
    w_valid   = 1'b0;
    ar_valid  = 1'b0;
    rsp_flit  = '0;
    rsp_valid = 1'b0;
    rst_n_i   = 1'b0;
    stall_req = 1'b0;
    stall_rsp = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    checks++;
    if (req_valid || axi_rsp.b_valid || axi_rsp.r_valid || !rsp_ready) begin
      errors++;
      $display("outputs not idle after reset");
    end

    start_test();
    send_write('{id: 4'h3, addr: 32'h0025_1000, len: 8'd3}, 1'b0);
    checks++;
    if (req_cyc_q.size() != 5 || req_cyc_q[4] - req_cyc_q[0] != 4) begin
      errors++;
      $display("write burst flits were not sent on 5 consecutive cycles");
    end
    finish_test("single write");

    start_test();
    send_read('{id: 4'h9, addr: 32'h8013_0040, len: 8'd0}, 1'b0);
    finish_test("single read");

    start_test();
    fork
      repeat (8) send_write(random_ax(4), 1'b1);
      repeat (10) send_read(random_ax(4), 1'b1);
    join
    finish_test("lane contention");

    start_test();
    stall_req <= 1'b1;
    fork
      repeat (6) send_write(random_ax(4), 1'b0);
      repeat (6) send_read(random_ax(2), 1'b0);
    join
    wait_drain();
    stall_req <= 1'b0;
    finish_test("request back-pressure");

    start_test();
    stall_rsp <= 1'b1;
    send_responses(40);
    wait_drain();
    stall_rsp <= 1'b0;
    finish_test("response delivery");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
